/* dv/centipede_io_properties.sv */
`timescale 1ns/1ps

module centipede_io_properties
(
   input logic                      s_6mhz,
   input logic                      reset,
   input centipede_pkg::cpu_bus_t   bus_i,
   input centipede_pkg::io_write_t  wr_i,
   input centipede_pkg::io_region_e rd_region_i,
   input logic [7:0]                rdata_i,
   input logic [4:1]                led_i,
   input logic                      flip_i,
   input logic [2:0]                coin_ctr_i
);
   import centipede_pkg::*;

   logic wr_present;

   // bus write as qualified on the board
   assign wr_present = bus_i.phi2 & ~bus_i.rw_n;

   // strobe only follows a presented write, and drops after one cycle
   a_wr_strobe: assert property (@(posedge s_6mhz) disable iff (reset)
      $rose(wr_i.valid) |=> (!wr_i.valid && $past(wr_present, 2)))
      else $error("write strobe not one cycle after a presented write");

   // dropped regions read as zero
   a_none_reads_zero: assert property (@(posedge s_6mhz) disable iff (reset)
      (rd_region_i == REG_NONE) |-> (rdata_i == 8'h00))
      else $error("read data not zero for an unmapped region");

   a_outputs_in_reset: assert property (@(posedge s_6mhz)
      reset |-> (led_i == 4'h0 && !flip_i && coin_ctr_i == 3'b000))
      else $error("output latch not cleared during reset");

endmodule

bind centipede_io centipede_io_properties i_centipede_io_properties (
   .s_6mhz      (s_6mhz),
   .reset       (reset),
   .bus_i       (bus_i),
   .wr_i        (wr),
   .rd_region_i (rd_region),
   .rdata_i     (rdata_o),
   .led_i       (led_o),
   .flip_i      (flip_o),
   .coin_ctr_i  (coin_ctr_o)
);

/* dv/tb_centipede_io.sv */
`timescale 1ns/1ps

module tb_centipede_io;
   import centipede_pkg::*;

   localparam int NUM_OPS        = 400;
   localparam int MAX_OP_CYCLES  = 14;
   // reset, directed colour fill and first high-score pass
   localparam int SETUP_CYCLES   = 400;
   localparam int TIMEOUT_CYCLES = NUM_OPS * MAX_OP_CYCLES + SETUP_CYCLES;

   logic       s_6mhz;
   logic       reset;
   cpu_bus_t   bus_i;
   player_in_t player_i;
   logic [7:0] joystick_i;
   trackball_t trackball_i;
   logic [7:0] sw1_i;
   logic [7:0] sw2_i;
   logic       vblank_i;
   logic [7:0] rdata_o;
   logic [4:1] led_o;
   logic       flip_o;
   logic [2:0] coin_ctr_o;

   // reference model state
   logic [7:0] m_latch;
   logic       m_h_dir;
   logic       m_v_dir;
   logic [3:0] m_h_cnt;
   logic [3:0] m_v_cnt;
   logic [3:0] m_color [16];
   logic       m_color_ok [16];
   logic [5:0] m_ea_addr;
   logic [7:0] m_ea_data;
   logic [3:0] m_ea_ctrl;
   logic [7:0] m_store [64];
   logic       m_store_ok [64];

   int out_errors;
   int read_errors;
   int cycles;

   centipede_io i_centipede_io (
      .s_6mhz      (s_6mhz),
      .reset       (reset),
      .bus_i       (bus_i),
      .player_i    (player_i),
      .joystick_i  (joystick_i),
      .trackball_i (trackball_i),
      .sw1_i       (sw1_i),
      .sw2_i       (sw2_i),
      .vblank_i    (vblank_i),
      .rdata_o     (rdata_o),
      .led_o       (led_o),
      .flip_o      (flip_o),
      .coin_ctr_o  (coin_ctr_o)
   );

   initial
   begin
      s_6mhz = 1'b0;
      forever #20 s_6mhz = ~s_6mhz;
   end

   // apply one write to the model, state as seen two edges after presenting it
   task automatic model_write(input logic [13:0] a, input logic [7:0] d);
      case (a[13:10])
         4'd5:
         begin
            if (!a[9])
            begin
               m_color[a[3:0]]    = d[3:0];
               m_color_ok[a[3:0]] = 1'b1;
            end
            else if (a[8:7] == 2'd0)
            begin
               m_ea_addr = a[5:0];
               m_ea_data = d;
            end
            else if (a[8:7] == 2'd1)
               m_ea_ctrl = d[3:0];
            // enabled store in write mode copies the data latch every edge
            if (a[9] && a[8:7] != 2'd2 && a[8:7] != 2'd3 &&
                m_ea_ctrl == (m_ea_ctrl & 4'b0101) && m_ea_ctrl[0] && m_ea_ctrl[2])
            begin
               m_store[m_ea_addr]    = m_ea_data;
               m_store_ok[m_ea_addr] = 1'b1;
            end
         end
         4'd7: m_latch[a[2:0]] = d[7];
         4'd9:
         begin
            m_h_cnt = 4'h0;
            m_v_cnt = 4'h0;
         end
         default: ;
      endcase
   endtask

   // read byte predicted from the port map, known low where memory is unwritten
   function automatic logic [7:0] expected_rdata(input logic [13:0] a, output logic known);
      logic [7:0] v;
      v     = 8'h00;
      known = 1'b1;
      case (a[13:10])
         4'd2: v = a[0] ? sw2_i : sw1_i;
         4'd3:
         begin
            if (a[1])
               v = a[0] ? joystick_i : {m_v_dir, 3'b000, m_v_cnt};
            else if (a[0])
               v = {player_i.coin_r | m_latch[2], player_i.coin_c | m_latch[1],
                    player_i.coin_l | m_latch[0], player_i.slam, player_i.fire2,
                    player_i.fire1, player_i.start1, player_i.start2};
            else
               v = {m_h_dir, vblank_i, player_i.self_test, player_i.cocktail, m_h_cnt};
         end
         4'd5:
         begin
            if (!a[9])
            begin
               known = m_color_ok[a[3:0]];
               v     = {4'h0, m_color[a[3:0]]};
            end
            else if (a[8:7] == 2'd2)
            begin
               known = m_ea_ctrl[0] && !m_ea_ctrl[3] && m_store_ok[m_ea_addr];
               v     = m_store[m_ea_addr];
            end
         end
         default: v = 8'h00;
      endcase
      return v;
   endfunction

   // write strobe: present for one edge, then idle
   task automatic bus_write(input logic [13:0] a, input logic [7:0] d);
      @(posedge s_6mhz);
      bus_i.addr  <= a;
      bus_i.wdata <= d;
      bus_i.rw_n  <= 1'b0;
      bus_i.phi2  <= 1'b1;
      @(posedge s_6mhz);
      bus_i.rw_n  <= 1'b1;
      bus_i.phi2  <= 1'b0;
      model_write(a, d);
   endtask

   // fresh player inputs with each read, sampled at the falling edge
   task automatic bus_read_check(input logic [13:0] a);
      logic [31:0] r;
      logic [31:0] s;
      logic [7:0]  exp;
      logic        known;
      r = $urandom();
      s = $urandom();
      @(posedge s_6mhz);
      bus_i.addr  <= a;
      bus_i.wdata <= r[7:0];
      bus_i.rw_n  <= 1'b1;
      bus_i.phi2  <= r[8];
      player_i    <= r[18:9];
      vblank_i    <= r[19];
      joystick_i  <= s[7:0];
      sw1_i       <= s[15:8];
      sw2_i       <= s[23:16];
      @(negedge s_6mhz);
      exp = expected_rdata(a, known);
      if (known && rdata_o !== exp)
      begin
         $display("[FAIL] %0t rdata_o addr=%h expected %h got %h", $time, a, exp, rdata_o);
         read_errors++;
      end
   endtask

   task automatic check_outputs();
      if (led_o !== m_latch[6:3])
      begin
         $display("[FAIL] %0t led_o expected %h got %h", $time, m_latch[6:3], led_o);
         out_errors++;
      end
      if (flip_o !== m_latch[7])
      begin
         $display("[FAIL] %0t flip_o expected %b got %b", $time, m_latch[7], flip_o);
         out_errors++;
      end
      if (coin_ctr_o !== m_latch[2:0])
      begin
         $display("[FAIL] %0t coin_ctr_o expected %b got %b", $time, m_latch[2:0], coin_ctr_o);
         out_errors++;
      end
   endtask

   // one step on a random axis of the player chosen by flip
   task automatic trackball_step();
      logic [31:0] r;
      logic        horiz;
      logic        dir;
      trackball_t  t;
      r     = $urandom();
      horiz = r[0];
      dir   = r[1];
      t     = '0;
      if (m_latch[7] && horiz)
         {t.p1_h_dir, t.p1_h_ck} = {dir, 1'b1};
      else if (m_latch[7])
         {t.p1_v_dir, t.p1_v_ck} = {dir, 1'b1};
      else if (horiz)
         {t.p2_h_dir, t.p2_h_ck} = {dir, 1'b1};
      else
         {t.p2_v_dir, t.p2_v_ck} = {dir, 1'b1};
      @(posedge s_6mhz);
      trackball_i <= t;
      repeat (6) @(posedge s_6mhz);
      t.p1_h_ck = 1'b0;
      t.p2_h_ck = 1'b0;
      t.p1_v_ck = 1'b0;
      t.p2_v_ck = 1'b0;
      trackball_i <= t;
      repeat (5) @(posedge s_6mhz);
      // count moves by the old direction, then the new one is latched
      if (horiz)
      begin
         m_h_cnt = m_h_dir ? m_h_cnt + 4'd1 : m_h_cnt - 4'd1;
         m_h_dir = dir;
      end
      else
      begin
         m_v_cnt = m_v_dir ? m_v_cnt + 4'd1 : m_v_cnt - 4'd1;
         m_v_dir = dir;
      end
      bus_read_check({4'd3, 8'h00, !horiz, 1'b0});
   endtask

   // address and data, write-enable pulse, then read mode and read back
   task automatic hiscore_sequence();
      logic [31:0] r;
      r = $urandom();
      bus_write({4'd5, 1'b1, 2'b00, r[6:0]}, r[15:8]);
      bus_write({4'd5, 1'b1, 2'b01, 7'h00}, {r[19:16], 4'b0101});
      repeat (3) @(posedge s_6mhz);
      bus_write({4'd5, 1'b1, 2'b01, 7'h00}, {r[23:20], 4'b0001});
      repeat (3) @(posedge s_6mhz);
      bus_read_check({4'd5, 1'b1, 2'b10, r[30:24]});
   endtask

   task automatic random_op();
      logic [31:0] r;
      logic [31:0] s;
      logic [3:0]  rg;
      r = $urandom();
      s = $urandom();
      case (r[3:0])
         4'd0, 4'd1, 4'd2:
         begin
            bus_write({4'd7, s[9:0]}, s[17:10]);
            @(posedge s_6mhz);
            @(negedge s_6mhz);
            check_outputs();
            bus_read_check({4'd3, 8'h00, 1'b0, 1'b1});
         end
         4'd3, 4'd4: bus_write({4'd5, 1'b0, s[8:0]}, s[17:10]);
         4'd5: bus_write({4'd9, s[9:0]}, s[17:10]);
         4'd6, 4'd7:
         begin
            // regions 5, 7 and 9 move to unmapped ones
            rg = s[13:10];
            if (rg == 4'd5 || rg == 4'd7 || rg == 4'd9)
               rg = rg ^ 4'b1000;
            if (s[14])
               bus_write({4'd5, 1'b1, 2'b11, s[6:0]}, s[22:15]);
            else
               bus_write({rg, s[9:0]}, s[22:15]);
         end
         4'd8, 4'd9, 4'd10, 4'd11:
         begin
            case (s[15:14])
               2'd0: bus_read_check(s[13:0]);
               2'd1: bus_read_check({4'd3, s[9:0]});
               2'd2: bus_read_check({4'd2, s[9:0]});
               default: bus_read_check({4'd5, s[9:0]});
            endcase
         end
         4'd15: hiscore_sequence();
         default: trackball_step();
      endcase
   endtask

   task automatic print_counts();
      $display("errors: outputs=%0d reads=%0d total=%0d", out_errors, read_errors,
               out_errors + read_errors);
   endtask

   // stops a hung run
   initial
   begin
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES)
      begin
         @(posedge s_6mhz);
         cycles++;
      end
      $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      print_counts();
      $display("sim failed");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      logic [3:0]  ci;
      void'($urandom(61112));
      out_errors  = 0;
      read_errors = 0;
      reset       = 1'b1;
      bus_i       = '{addr: 14'h0000, wdata: 8'h00, rw_n: 1'b1, phi2: 1'b0};
      player_i    = '0;
      joystick_i  = 8'h00;
      trackball_i = '0;
      sw1_i       = 8'h00;
      sw2_i       = 8'h00;
      vblank_i    = 1'b0;
      m_latch     = 8'h00;
      m_h_dir     = 1'b0;
      m_v_dir     = 1'b0;
      m_h_cnt     = 4'h0;
      m_v_cnt     = 4'h0;
      m_ea_addr   = 6'h00;
      m_ea_data   = 8'h00;
      m_ea_ctrl   = 4'h0;
      for (int i = 0; i < 16; i++)
         m_color_ok[i] = 1'b0;
      for (int i = 0; i < 64; i++)
         m_store_ok[i] = 1'b0;

      repeat (4) @(posedge s_6mhz);
      reset <= 1'b0;
      @(negedge s_6mhz);
      check_outputs();
      // both trackball ports, counts and directions cleared
      bus_read_check({4'd3, 8'h00, 2'b00});
      bus_read_check({4'd3, 8'h00, 2'b10});

      // colour ram fill, then random read-back
      for (int i = 0; i < 16; i++)
      begin
         r  = $urandom();
         ci = i[3:0];
         bus_write({4'd5, 1'b0, r[4:0], ci}, r[15:8]);
      end
      for (int i = 0; i < 16; i++)
      begin
         r = $urandom();
         bus_read_check({4'd5, 1'b0, r[8:0]});
      end

      hiscore_sequence();

      for (int n = 0; n < NUM_OPS; n++)
         random_op();

      print_counts();
      if (out_errors + read_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* hdl/centipede_consts.svh */
`ifndef CENTIPEDE_CONSTS_SVH
`define CENTIPEDE_CONSTS_SVH

// processor bus widths
`define CPU_ADDR_W      14
`define CPU_DATA_W      8

// address bits that pick one 1k region
`define REGION_MSB      13
`define REGION_LSB      10

// region codes seen on addr[13:10]
`define REGION_SWITCH   4'd2
`define REGION_IN       4'd3
`define REGION_EA       4'd5
`define REGION_OUT0     4'd7
`define REGION_STEERCLR 4'd9

// high-score store and colour ram sizes
`define EAROM_ADDR_W    6
`define EAROM_CTRL_W    4
`define COLOR_ADDR_W    4
`define COLOR_DATA_W    4

// trackball up/down counter width
`define TB_CNT_W        4

// output latch bit positions, leds take bits 3..6
`define OUT_FLIP        7
`define OUT_LED_LSB     3
`define OUT_COIN_R      2
`define OUT_COIN_C      1
`define OUT_COIN_L      0

`endif

/* hdl/centipede_io.sv */
`timescale 1ns/1ps
`include "centipede_consts.svh"

module centipede_io
(
   input  logic                      s_6mhz,
   input  logic                      reset,
   input  centipede_pkg::cpu_bus_t   bus_i,
   input  centipede_pkg::player_in_t player_i,
   input  logic [`CPU_DATA_W-1:0]    joystick_i,
   input  centipede_pkg::trackball_t trackball_i,
   input  logic [`CPU_DATA_W-1:0]    sw1_i,
   input  logic [`CPU_DATA_W-1:0]    sw2_i,
   input  logic                      vblank_i,
   output logic [`CPU_DATA_W-1:0]    rdata_o,
   output logic [4:1]                led_o,
   output logic                      flip_o,
   output logic [2:0]                coin_ctr_o
);
   import centipede_pkg::*;

   io_region_e               rd_region;
   io_write_t                wr;
   tb_count_t                tb_count;
   logic [`COLOR_DATA_W-1:0] color_data;
   logic [`CPU_DATA_W-1:0]   earom_data;

   // bus decode and write strobe
   io_addr_decode i_io_addr_decode (
      .s_6mhz      (s_6mhz),
      .reset       (reset),
      .bus_i       (bus_i),
      .rd_region_o (rd_region),
      .wr_o        (wr)
   );

   // flip from the output latch also picks the trackball player
   trackball_counter i_trackball_counter (
      .s_6mhz      (s_6mhz),
      .reset       (reset),
      .trackball_i (trackball_i),
      .flip_i      (flip_o),
      .wr_i        (wr),
      .count_o     (tb_count)
   );

   coin_output_latch i_coin_output_latch (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .wr_i       (wr),
      .flip_o     (flip_o),
      .led_o      (led_o),
      .coin_ctr_o (coin_ctr_o)
   );

   color_ram i_color_ram (
      .s_6mhz    (s_6mhz),
      .wr_i      (wr),
      .rd_addr_i (bus_i.addr[`COLOR_ADDR_W-1:0]),
      .rd_data_o (color_data)
   );

   hiscore_earom i_hiscore_earom (
      .s_6mhz    (s_6mhz),
      .reset     (reset),
      .wr_i      (wr),
      .rd_data_o (earom_data)
   );

   // combinational read path
   io_read_mux i_io_read_mux (
      .rd_region_i (rd_region),
      .addr0_i     (bus_i.addr[0]),
      .player_i    (player_i),
      .joystick_i  (joystick_i),
      .sw1_i       (sw1_i),
      .sw2_i       (sw2_i),
      .vblank_i    (vblank_i),
      .coin_ctr_i  (coin_ctr_o),
      .count_i     (tb_count),
      .color_i     (color_data),
      .earom_i     (earom_data),
      .rdata_o     (rdata_o)
   );

endmodule

/* hdl/centipede_pkg.sv */
`include "centipede_consts.svh"

package centipede_pkg;

   // decoded i/o regions of the 6502 bus
   typedef enum logic [3:0]
   {
      REG_NONE,
      REG_SWITCH,
      REG_IN0,
      REG_IN1,
      REG_COLOR,
      REG_EA_ADDR,
      REG_EA_CTRL,
      REG_EA_READ,
      REG_OUT0,
      REG_STEERCLR
   } io_region_e;

   // external processor bus as seen by the i/o section
   typedef struct packed
   {
      logic [`CPU_ADDR_W-1:0] addr;
      logic [`CPU_DATA_W-1:0] wdata;
      logic                   rw_n;
      logic                   phi2;
   } cpu_bus_t;

   // registered write strobe with captured address and data
   typedef struct packed
   {
      logic                   valid;
      io_region_e             region;
      logic [`REGION_LSB-1:0] addr;
      logic [`CPU_DATA_W-1:0] data;
   } io_write_t;

   // player switches, msb first as on the board
   typedef struct packed
   {
      logic coin_r;
      logic coin_c;
      logic coin_l;
      logic self_test;
      logic cocktail;
      logic slam;
      logic start1;
      logic start2;
      logic fire2;
      logic fire1;
   } player_in_t;

   // mini-trackball direction and step clock lines for both players
   typedef struct packed
   {
      logic p1_h_dir;
      logic p2_h_dir;
      logic p1_h_ck;
      logic p2_h_ck;
      logic p1_v_dir;
      logic p2_v_dir;
      logic p1_v_ck;
      logic p2_v_ck;
   } trackball_t;

   // latched direction and step count per axis
   typedef struct packed
   {
      logic                 h_dir;
      logic [`TB_CNT_W-1:0] h_cnt;
      logic                 v_dir;
      logic [`TB_CNT_W-1:0] v_cnt;
   } tb_count_t;

endpackage

/* hdl/coin_output_latch.sv */
`timescale 1ns/1ps
`include "centipede_consts.svh"

module coin_output_latch
(
   input  logic                     s_6mhz,
   input  logic                     reset,
   input  centipede_pkg::io_write_t wr_i,
   output logic                     flip_o,
   output logic [4:1]               led_o,
   output logic [2:0]               coin_ctr_o
);
   import centipede_pkg::*;

   logic [7:0] latch_q;

   // addressable latch, addr[2:0] picks the bit and data bit 7 is the value
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         latch_q <= '0;
      else if (wr_i.valid && (wr_i.region == REG_OUT0))
         latch_q[wr_i.addr[2:0]] <= wr_i.data[7];
   end

   assign flip_o = latch_q[`OUT_FLIP];
   assign led_o  = latch_q[`OUT_LED_LSB +: 4];
   // right, centre, left counter drives
   assign coin_ctr_o = {latch_q[`OUT_COIN_R], latch_q[`OUT_COIN_C], latch_q[`OUT_COIN_L]};

endmodule

/* hdl/color_ram.sv */
`timescale 1ns/1ps
`include "centipede_consts.svh"

module color_ram
(
   input  logic                     s_6mhz,
   input  centipede_pkg::io_write_t wr_i,
   input  logic [`COLOR_ADDR_W-1:0] rd_addr_i,
   output logic [`COLOR_DATA_W-1:0] rd_data_o
);
   import centipede_pkg::*;

   logic [`COLOR_DATA_W-1:0] mem [2**`COLOR_ADDR_W];

   // processor side only, low nibble of the data byte
   always_ff @(posedge s_6mhz)
   begin
      if (wr_i.valid && (wr_i.region == REG_COLOR))
         mem[wr_i.addr[`COLOR_ADDR_W-1:0]] <= wr_i.data[`COLOR_DATA_W-1:0];
   end

   // asynchronous read port
   assign rd_data_o = mem[rd_addr_i];

endmodule

/* hdl/hiscore_earom.sv */
`timescale 1ns/1ps
`include "centipede_consts.svh"

module hiscore_earom
(
   input  logic                     s_6mhz,
   input  logic                     reset,
   input  centipede_pkg::io_write_t wr_i,
   output logic [`CPU_DATA_W-1:0]   rd_data_o
);
   import centipede_pkg::*;

   logic [`EAROM_ADDR_W-1:0] addr_q;
   logic [`CPU_DATA_W-1:0]   data_q;
   logic [`EAROM_CTRL_W-1:0] ctrl_q;
   logic [`CPU_DATA_W-1:0]   out_q;
   logic                     store_en;
   logic                     store_we;
   logic [`CPU_DATA_W-1:0]   mem [2**`EAROM_ADDR_W];

   // an address write also captures the byte to be stored
   always_ff @(posedge s_6mhz)
   begin
      if (wr_i.valid && (wr_i.region == REG_EA_ADDR))
      begin
         addr_q <= wr_i.addr[`EAROM_ADDR_W-1:0];
         data_q <= wr_i.data;
      end
   end

   // control latch, zero keeps the store idle
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         ctrl_q <= '0;
      else if (wr_i.valid && (wr_i.region == REG_EA_CTRL))
         ctrl_q <= wr_i.data[`EAROM_CTRL_W-1:0];
   end

   // bit 0 clocks the part unless bit 3 holds it off
   assign store_en = ctrl_q[0] & ~ctrl_q[3];
   // bit 2 high with bit 1 low selects a write
   assign store_we = ctrl_q[2] & ~ctrl_q[1];

   // output refreshes on every enabled edge, old contents on a write
   always_ff @(posedge s_6mhz)
   begin
      if (store_en)
      begin
         if (store_we)
            mem[addr_q] <= data_q;
         out_q <= mem[addr_q];
      end
   end

   assign rd_data_o = out_q;

endmodule

/* hdl/io_addr_decode.sv */
`timescale 1ns/1ps
`include "centipede_consts.svh"

module io_addr_decode
(
   input  logic                      s_6mhz,
   input  logic                      reset,
   input  centipede_pkg::cpu_bus_t   bus_i,
   output centipede_pkg::io_region_e rd_region_o,
   output centipede_pkg::io_write_t  wr_o
);
   import centipede_pkg::*;

   logic [`REGION_MSB-`REGION_LSB:0] region_bits;
   logic                             wr_present;
   logic                             wr_valid_q;
   io_region_e                       wr_region_q;
   logic [`REGION_LSB-1:0]           wr_addr_q;
   logic [`CPU_DATA_W-1:0]           wr_data_q;

   assign region_bits = bus_i.addr[`REGION_MSB:`REGION_LSB];

   // same qualifier the board used for its write strobe
   assign wr_present = bus_i.phi2 & ~bus_i.rw_n;

   always_comb
   begin
      rd_region_o = REG_NONE;
      case (region_bits)
         `REGION_SWITCH: rd_region_o = REG_SWITCH;
         // addr bit 1 splits the two input ports
         `REGION_IN:     rd_region_o = bus_i.addr[1] ? REG_IN1 : REG_IN0;
         `REGION_EA:
         begin
            // bit 9 low is colour ram, high is the earom group
            if (!bus_i.addr[9])
               rd_region_o = REG_COLOR;
            else if (bus_i.addr[8:7] == 2'd0)
               rd_region_o = REG_EA_ADDR;
            else if (bus_i.addr[8:7] == 2'd1)
               rd_region_o = REG_EA_CTRL;
            else if (bus_i.addr[8:7] == 2'd2)
               rd_region_o = REG_EA_READ;
         end
         `REGION_OUT0:   rd_region_o = REG_OUT0;
         // bit 13 reads belong to program rom, only the write side is kept
         `REGION_STEERCLR:
         begin
            if (!bus_i.rw_n)
               rd_region_o = REG_STEERCLR;
         end
         default:        rd_region_o = REG_NONE;
      endcase
   end

   // one-cycle strobe, acted on by the targets at the following edge
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         wr_valid_q <= 1'b0;
      else
         wr_valid_q <= wr_present;
   end

   // captured address and data
   always_ff @(posedge s_6mhz)
   begin
      if (wr_present)
      begin
         wr_region_q <= rd_region_o;
         wr_addr_q   <= bus_i.addr[`REGION_LSB-1:0];
         wr_data_q   <= bus_i.wdata;
      end
   end

   always_comb
   begin
      wr_o.valid  = wr_valid_q;
      wr_o.region = wr_region_q;
      wr_o.addr   = wr_addr_q;
      wr_o.data   = wr_data_q;
   end

endmodule

/* hdl/io_read_mux.sv */
`timescale 1ns/1ps
`include "centipede_consts.svh"

module io_read_mux
(
   input  centipede_pkg::io_region_e rd_region_i,
   input  logic                      addr0_i,
   input  centipede_pkg::player_in_t player_i,
   input  logic [`CPU_DATA_W-1:0]    joystick_i,
   input  logic [`CPU_DATA_W-1:0]    sw1_i,
   input  logic [`CPU_DATA_W-1:0]    sw2_i,
   input  logic                      vblank_i,
   input  logic [2:0]                coin_ctr_i,
   input  centipede_pkg::tb_count_t  count_i,
   input  logic [`COLOR_DATA_W-1:0]  color_i,
   input  logic [`CPU_DATA_W-1:0]    earom_i,
   output logic [`CPU_DATA_W-1:0]    rdata_o
);
   import centipede_pkg::*;

   logic [`CPU_DATA_W-1:0] in0_hi;
   logic [`CPU_DATA_W-1:0] in0_lo;
   logic [`CPU_DATA_W-1:0] in1_lo;

   // a driven coin counter reads back as an active coin line
   assign in0_hi = {player_i.coin_r | coin_ctr_i[2],
                    player_i.coin_c | coin_ctr_i[1],
                    player_i.coin_l | coin_ctr_i[0],
                    player_i.slam, player_i.fire2, player_i.fire1,
                    player_i.start1, player_i.start2};
   // horizontal trackball shares the port with vblank and cabinet bits
   assign in0_lo = {count_i.h_dir, vblank_i, player_i.self_test, player_i.cocktail,
                    count_i.h_cnt};
   assign in1_lo = {count_i.v_dir, 3'b000, count_i.v_cnt};

   always_comb
   begin
      case (rd_region_i)
         REG_IN0:     rdata_o = addr0_i ? in0_hi : in0_lo;
         REG_IN1:     rdata_o = addr0_i ? joystick_i : in1_lo;
         REG_SWITCH:  rdata_o = addr0_i ? sw2_i : sw1_i;
         // colour ram is only four bits wide
         REG_COLOR:   rdata_o = {{(`CPU_DATA_W-`COLOR_DATA_W){1'b0}}, color_i};
         REG_EA_READ: rdata_o = earom_i;
         default:     rdata_o = '0;
      endcase
   end

endmodule

/* hdl/trackball_counter.sv */
`timescale 1ns/1ps
`include "centipede_consts.svh"

module trackball_counter
(
   input  logic                      s_6mhz,
   input  logic                      reset,
   input  centipede_pkg::trackball_t trackball_i,
   input  logic                      flip_i,
   input  centipede_pkg::io_write_t  wr_i,
   output centipede_pkg::tb_count_t  count_o
);
   import centipede_pkg::*;

   // index 1 is the horizontal axis, index 0 the vertical one
   logic [1:0]                ck_sel;
   logic [1:0]                dir_sel;
   logic [1:0]                ck_s1;
   logic [1:0]                ck_s2;
   logic [1:0]                ck_d;
   logic [1:0]                dir_s1;
   logic [1:0]                dir_s2;
   logic [1:0]                step;
   logic [1:0]                dir_q;
   logic [1:0][`TB_CNT_W-1:0] cnt_q;
   logic                      steer_clr;

   // screen flip picks which player owns the trackball
   assign ck_sel  = flip_i ? {trackball_i.p1_h_ck, trackball_i.p1_v_ck}
                           : {trackball_i.p2_h_ck, trackball_i.p2_v_ck};
   assign dir_sel = flip_i ? {trackball_i.p1_h_dir, trackball_i.p1_v_dir}
                           : {trackball_i.p2_h_dir, trackball_i.p2_v_dir};

   // two-flop synchronisers, direction follows the clock path
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         ck_s1  <= '0;
         ck_s2  <= '0;
         ck_d   <= '0;
         dir_s1 <= '0;
         dir_s2 <= '0;
      end
      else
      begin
         ck_s1  <= ck_sel;
         ck_s2  <= ck_s1;
         ck_d   <= ck_s2;
         dir_s1 <= dir_sel;
         dir_s2 <= dir_s1;
      end
   end

   // rising step clock
   assign step = ck_s2 & ~ck_d;

   assign steer_clr = wr_i.valid && (wr_i.region == REG_STEERCLR);

   // count uses the direction latched on the previous step
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         dir_q <= '0;
         cnt_q <= '0;
      end
      else
      begin
         for (int a = 0; a < 2; a++)
         begin
            if (step[a])
               dir_q[a] <= dir_s2[a];
            // steering clear leaves the direction bits alone
            if (steer_clr)
               cnt_q[a] <= '0;
            else if (step[a])
               cnt_q[a] <= dir_q[a] ? cnt_q[a] + 1'b1 : cnt_q[a] - 1'b1;
         end
      end
   end

   always_comb
   begin
      count_o.h_dir = dir_q[1];
      count_o.h_cnt = cnt_q[1];
      count_o.v_dir = dir_q[0];
      count_o.v_cnt = cnt_q[0];
   end

endmodule

/* run.sh */
#!/bin/sh
# build and run the centipede i/o testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_centipede_io -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
   exit 0
fi
exit 1

/* sources.f */
+incdir+hdl
hdl/centipede_pkg.sv
hdl/io_addr_decode.sv
hdl/trackball_counter.sv
hdl/coin_output_latch.sv
hdl/color_ram.sv
hdl/hiscore_earom.sv
hdl/io_read_mux.sv
hdl/centipede_io.sv
dv/centipede_io_properties.sv
dv/tb_centipede_io.sv
